//--- design/dsp16_types_pkg.sv
// DSP16 Y-AAU common widths
// Vector types for data words, pointer addresses and instruction words

package dsp16_types_pkg;

    // Word widths
    localparam int data_w    = 16;
    localparam int addr_w    = 11;
    localparam int instr_w   = 16;
    localparam int ptr_sel_w = 2;

    // Pointer file r0 to r3
    localparam int num_ptr = 4;

    // RAM depth in address bits, full pointer range by default
    localparam int default_ram_aw = 11;

    // RAM data word
    typedef logic [data_w-1:0] data_t;

    // Pointer value or RAM address, wraps modulo 2048
    typedef logic [addr_w-1:0] addr_t;

    // Instruction word
    typedef logic [instr_w-1:0] instr_t;

    // Pointer index from the r field
    typedef logic [ptr_sel_w-1:0] ptr_sel_t;

endpackage

//--- design/dsp16_isa_pkg.sv
// DSP16 Y-AAU instruction set
// Opcode and modify encodings, field positions and decoder control structs

package dsp16_isa_pkg;

    import dsp16_types_pkg::*;

    // Opcode in bits 15..13, codes 5 to 7 raise the fault level
    typedef enum logic [2:0] {
        op_nop      = 3'd0,
        op_load_ptr = 3'd1,
        op_load_j   = 3'd2,
        op_read     = 3'd3,
        op_write    = 3'd4
    } opcode_e;

    // Post-modify of the selected pointer after an access
    typedef enum logic [1:0] {
        mod_none  = 2'd0,
        mod_inc   = 2'd1,
        mod_dec   = 2'd2,
        mod_add_j = 2'd3
    } modify_e;

    // Opcode field
    localparam int op_msb = 15;
    localparam int op_lsb = 13;

    // Pointer select, like the DSP16 r field
    localparam int r_msb = 12;
    localparam int r_lsb = 11;

    // 11-bit immediate for pointer and j loads
    localparam int imm_msb = 10;
    localparam int imm_lsb = 0;

    // Modify field, shares the upper immediate bits
    localparam int mod_msb = 10;
    localparam int mod_lsb = 9;

    // Command to one pointer unit
    typedef struct packed {
        logic  load;
        addr_t load_value;
        logic  step_en;
        addr_t step;        // already reduced to 11 bits
    } ptr_cmd_t;

    // RAM access request
    typedef struct packed {
        logic     valid;
        logic     write;
        ptr_sel_t sel;
        data_t    wdata;
    } mem_req_t;

endpackage

//--- design/yaau_decode.sv
// Y-AAU instruction decoder
// Registers pointer commands and RAM requests, holds j and the sticky fault

`timescale 1ns/1ps

module yaau_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp16_types_pkg::instr_t  instr,
    input  logic                     instr_valid,
    input  dsp16_types_pkg::data_t   wdata,
    output dsp16_isa_pkg::ptr_cmd_t  ptr_cmd [dsp16_types_pkg::num_ptr],
    output dsp16_isa_pkg::mem_req_t  mem_req,
    output logic                     fault
);

    import dsp16_types_pkg::*;
    import dsp16_isa_pkg::*;

    // Instruction fields
    opcode_e  opcode;
    ptr_sel_t r_sel;
    modify_e  modify;
    addr_t    imm;

    // Step register j
    addr_t    j;

    addr_t    step;
    logic     access;
    logic     undefined;

    ptr_cmd_t cmd_next [num_ptr];
    mem_req_t req_next;

    assign opcode = opcode_e'(instr[op_msb:op_lsb]);
    assign r_sel  = instr[r_msb:r_lsb];
    assign modify = modify_e'(instr[mod_msb:mod_lsb]);
    assign imm    = instr[imm_msb:imm_lsb];

    // Opcode classes
    always_comb begin
        access    = 1'b0;
        undefined = 1'b0;
        case (opcode)
            op_nop, op_load_ptr, op_load_j: begin
                access = 1'b0;
            end
            op_read, op_write: begin
                access = 1'b1;
            end
            default: begin
                undefined = 1'b1;
            end
        endcase
    end

    // Signed step as an 11-bit value, minus one is all ones
    always_comb begin
        case (modify)
            mod_inc:   step = addr_t'(1);
            mod_dec:   step = '1;
            mod_add_j: step = j;
            default:   step = '0;
        endcase
    end

    // Only the selected pointer gets a command
    always_comb begin
        for (int i = 0; i < num_ptr; i++) begin
            cmd_next[i] = '0;
            if (instr_valid && r_sel == ptr_sel_t'(i)) begin
                cmd_next[i].load       = (opcode == op_load_ptr);
                cmd_next[i].load_value = imm;
                cmd_next[i].step_en    = access && (modify != mod_none);
                cmd_next[i].step       = step;
            end
        end
    end

    always_comb begin
        req_next.valid = instr_valid && access;
        req_next.write = (opcode == op_write);
        req_next.sel   = r_sel;
        req_next.wdata = wdata;
    end

    // Commands and requests are one-cycle strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_ptr; i++) begin
                ptr_cmd[i] <= '0;
            end
            mem_req <= '0;
        end else if (cen) begin
            ptr_cmd <= cmd_next;
            mem_req <= req_next;
        end
    end

    // j updates at the accepting edge
    always_ff @(posedge clk) begin
        if (rst) begin
            j <= '0;
        end else if (cen && instr_valid && opcode == op_load_j) begin
            j <= imm;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            fault <= 1'b0;
        end else if (cen && instr_valid && undefined) begin
            fault <= 1'b1;
        end
    end

endmodule

//--- design/yaau_ptr.sv
// Y-AAU pointer register
// One of r0..r3, loaded by immediate or post-modified by a step

`timescale 1ns/1ps

module yaau_ptr (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp16_isa_pkg::ptr_cmd_t  cmd,
    output dsp16_types_pkg::addr_t   ptr_value
);

    import dsp16_types_pkg::*;
    import dsp16_isa_pkg::*;

    addr_t next_value;
    addr_t stepped;

    // 11-bit sum, so the result wraps modulo 2048
    assign stepped = ptr_value + cmd.step;

    // Load wins over step
    always_comb begin
        if (cmd.load) begin
            next_value = cmd.load_value;
        end else if (cmd.step_en) begin
            next_value = stepped;
        end else begin
            next_value = ptr_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_value <= '0;
        end else if (cen) begin
            ptr_value <= next_value;
        end
    end

endmodule

//--- design/yaau_ram_port.sv
// Y-AAU data RAM port
// Addresses the RAM with the requesting pointer, writes or registers read data

`timescale 1ns/1ps

module yaau_ram_port #(
    parameter int ram_aw = dsp16_types_pkg::default_ram_aw
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp16_isa_pkg::mem_req_t  mem_req,
    input  dsp16_types_pkg::addr_t   ptr_values [dsp16_types_pkg::num_ptr],
    output dsp16_types_pkg::data_t   rdata,
    output logic                     rdata_valid
);

    import dsp16_types_pkg::*;
    import dsp16_isa_pkg::*;

    localparam int ram_words = 1 << ram_aw;

    data_t             ram [ram_words];
    addr_t             ptr_sel_value;
    logic [ram_aw-1:0] ram_addr;
    logic              ram_we;
    logic              ram_re;

    // Pre-modify value, the pointer steps at this same edge
    assign ptr_sel_value = ptr_values[mem_req.sel];
    assign ram_addr      = ptr_sel_value[ram_aw-1:0];

    assign ram_we = mem_req.valid && mem_req.write;
    assign ram_re = mem_req.valid && !mem_req.write;

    always_ff @(posedge clk) begin
        if (cen && ram_we) begin
            ram[ram_addr] <= mem_req.wdata;
        end
    end

    // Holds the last word read between reads
    always_ff @(posedge clk) begin
        if (cen && ram_re) begin
            rdata <= ram[ram_addr];
        end
    end

    // Pulse lasts until the next enabled edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else if (cen) begin
            rdata_valid <= ram_re;
        end
    end

endmodule

//--- design/dsp16_yaau.sv
// DSP16 RAM address arithmetic unit with data RAM
// Decoder, four post-modify pointers and the RAM port

`timescale 1ns/1ps

module dsp16_yaau #(
    parameter int ram_aw = dsp16_types_pkg::default_ram_aw
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  dsp16_types_pkg::instr_t  instr,
    input  logic                     instr_valid,
    input  dsp16_types_pkg::data_t   wdata,
    output dsp16_types_pkg::data_t   rdata,
    output logic                     rdata_valid,
    output logic                     fault
);

    import dsp16_types_pkg::*;
    import dsp16_isa_pkg::*;

    // Decoder to pointers
    ptr_cmd_t ptr_cmd [num_ptr];

    // Decoder to RAM port
    mem_req_t mem_req;

    // Current r0..r3
    addr_t    ptr_values [num_ptr];

    yaau_decode u_decode (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cen         ( cen         ),
        .instr       ( instr       ),
        .instr_valid ( instr_valid ),
        .wdata       ( wdata       ),
        .ptr_cmd     ( ptr_cmd     ),
        .mem_req     ( mem_req     ),
        .fault       ( fault       )
    );

    generate
        for (genvar i = 0; i < num_ptr; i++) begin : gen_ptr
            yaau_ptr u_ptr (
                .clk       ( clk           ),
                .rst       ( rst           ),
                .cen       ( cen           ),
                .cmd       ( ptr_cmd[i]    ),
                .ptr_value ( ptr_values[i] )
            );
        end
    endgenerate

    yaau_ram_port #(
        .ram_aw ( ram_aw )
    ) u_ram_port (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cen         ( cen         ),
        .mem_req     ( mem_req     ),
        .ptr_values  ( ptr_values  ),
        .rdata       ( rdata       ),
        .rdata_valid ( rdata_valid )
    );

endmodule

//--- testbench/dsp16_yaau_properties.sv
// Y-AAU timing and fault assertions
// Bound to the top level, checks reset values, sticky fault and read latency

`timescale 1ns/1ps

module dsp16_yaau_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input dsp16_types_pkg::instr_t instr,
    input logic                    instr_valid,
    input logic                    rdata_valid,
    input logic                    fault
);

    import dsp16_isa_pkg::*;

    logic read_accept;

    assign read_accept = cen && instr_valid && (instr[op_msb:op_lsb] == op_read);

    // Outputs cleared by reset
    assert property (@(posedge clk) rst |=> (!rdata_valid && !fault))
        else $error("rdata_valid or fault not low after reset");

    // Fault only clears through reset
    assert property (@(posedge clk) (fault && !rst) |=> fault)
        else $error("fault fell while reset was low");

    // E0 accepts, E1 is the next enabled edge, valid is seen after E1
    assert property (@(posedge clk) disable iff (rst)
        read_accept |=> cen[->1] ##1 rdata_valid)
        else $error("rdata_valid missing two enabled edges after a read");

endmodule

bind dsp16_yaau dsp16_yaau_properties u_properties (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .cen         ( cen         ),
    .instr       ( instr       ),
    .instr_valid ( instr_valid ),
    .rdata_valid ( rdata_valid ),
    .fault       ( fault       )
);

//--- testbench/dsp16_yaau_tb.sv
// DSP16 Y-AAU testbench
// Directed stimulus table with cycle-exact checks, then random instructions

`timescale 1ns/1ps

module dsp16_yaau_tb;

    import dsp16_types_pkg::*;
    import dsp16_isa_pkg::*;

    // One stimulus row and its expected read result
    typedef struct packed {
        logic   cen;
        logic   valid;
        instr_t instr;
        data_t  wdata;
        logic   exp_read;
        data_t  exp_data;
    } row_t;

    logic   clk;
    logic   rst;
    logic   cen;
    instr_t instr;
    logic   instr_valid;
    data_t  wdata;
    data_t  rdata;
    logic   rdata_valid;
    logic   fault;

    row_t  rows [$];
    row_t  last_row;

    // Expected outputs after the most recent edge
    logic  exp_valid;
    logic  exp_fault;
    data_t exp_rdata;
    logic  have_rdata;
    logic  pend_read;
    data_t pend_data;

    // Reference model for the random phase
    addr_t       ref_ptr [num_ptr];
    addr_t       ref_j;
    data_t       ref_ram [1 << default_ram_aw];
    logic [31:0] lcg_state;

    dsp16_yaau UUT (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .cen         ( cen         ),
        .instr       ( instr       ),
        .instr_valid ( instr_valid ),
        .wdata       ( wdata       ),
        .rdata       ( rdata       ),
        .rdata_valid ( rdata_valid ),
        .fault       ( fault       )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic instr_t make_instr(input logic [2:0] op, input logic [1:0] r,
                                          input logic [10:0] imm);
        return {op, r, imm};
    endfunction

    function automatic instr_t make_access(input logic [2:0] op, input logic [1:0] r,
                                           input logic [1:0] md);
        return {op, r, md, 9'd0};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Fill word uses every address bit
    function automatic data_t fill_word(input addr_t a);
        return {a[4:0], a} ^ 16'h5ac3;
    endfunction

    function automatic addr_t step_ptr(input addr_t p, input logic [1:0] md, input addr_t jv);
        case (md)
            mod_inc:   return p + 11'd1;
            mod_dec:   return p - 11'd1;
            mod_add_j: return p + jv;
            default:   return p;
        endcase
    endfunction

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic add_row(input logic c, input logic v, input instr_t i, input data_t w,
                           input logic er, input data_t ed);
        row_t r;
        r.cen      = c;
        r.valid    = v;
        r.instr    = i;
        r.wdata    = w;
        r.exp_read = er;
        r.exp_data = ed;
        rows.push_back(r);
    endtask

    task automatic add_idle(input int count);
        for (int n = 0; n < count; n++) begin
            add_row(1'b1, 1'b0, '0, '0, 1'b0, '0);
        end
    endtask

    task automatic drive_row(input row_t r);
        @(posedge clk);
        cen         <= r.cen;
        instr_valid <= r.valid;
        instr       <= r.instr;
        wdata       <= r.wdata;
    endtask

    // Expected outputs after an edge that applied row a
    task automatic advance_expect(input row_t a);
        if (a.cen) begin
            exp_valid = pend_read;
            if (pend_read) begin
                exp_rdata  = pend_data;
                have_rdata = 1'b1;
            end
            pend_read = a.valid && a.exp_read;
            pend_data = a.exp_data;
            if (a.valid && a.instr[op_msb:op_lsb] > 3'd4) begin
                exp_fault = 1'b1;
            end
        end
    endtask

    task automatic run_row(input row_t r);
        drive_row(r);
        advance_expect(last_row);
        last_row = r;
        @(negedge clk);
        check_value("rdata_valid", rdata_valid, exp_valid);
        check_value("fault", fault, exp_fault);
        if (have_rdata) begin
            check_value("rdata", rdata, exp_rdata);
        end
    endtask

    task automatic apply_reset();
        rst         <= 1'b1;
        cen         <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        wdata       <= '0;
        repeat (4) @(posedge clk);
        rst        <= 1'b0;
        last_row   = '0;
        last_row.cen = 1'b1;
        exp_valid  = 1'b0;
        exp_fault  = 1'b0;
        have_rdata = 1'b0;
        pend_read  = 1'b0;
    endtask

    task automatic build_table();
        // Write and read back through r0
        add_row(1, 1, make_instr(op_load_ptr, 0, 11'h100), '0, 0, '0);
        add_row(1, 1, make_access(op_write, 0, mod_none), 16'h1234, 0, '0);
        add_row(1, 1, make_access(op_read, 0, mod_none), '0, 1, 16'h1234);
        add_idle(2);
        // Post-increment writes, then reads up and down
        add_row(1, 1, make_instr(op_load_ptr, 1, 11'h200), '0, 0, '0);
        add_row(1, 1, make_instr(op_load_ptr, 2, 11'h200), '0, 0, '0);
        for (int k = 1; k <= 5; k++) begin
            add_row(1, 1, make_access(op_write, 1, mod_inc), 16'ha000 + k, 0, '0);
        end
        for (int k = 1; k <= 5; k++) begin
            add_row(1, 1, make_access(op_read, 2, mod_inc), '0, 1, 16'ha000 + k);
        end
        add_row(1, 1, make_instr(op_load_ptr, 2, 11'h204), '0, 0, '0);
        for (int k = 5; k >= 1; k--) begin
            add_row(1, 1, make_access(op_read, 2, mod_dec), '0, 1, 16'ha000 + k);
        end
        add_idle(2);
        // j of minus 3 walks r3 from 3 through 0 to 2045
        add_row(1, 1, make_instr(op_load_j, 0, 11'h7fd), '0, 0, '0);
        add_row(1, 1, make_instr(op_load_ptr, 3, 11'd3), '0, 0, '0);
        add_row(1, 1, make_access(op_write, 3, mod_add_j), 16'hb003, 0, '0);
        add_row(1, 1, make_access(op_write, 3, mod_add_j), 16'hb000, 0, '0);
        add_row(1, 1, make_access(op_write, 3, mod_add_j), 16'hb7fd, 0, '0);
        add_row(1, 1, make_instr(op_load_ptr, 3, 11'd3), '0, 0, '0);
        add_row(1, 1, make_access(op_read, 3, mod_add_j), '0, 1, 16'hb003);
        add_row(1, 1, make_access(op_read, 3, mod_add_j), '0, 1, 16'hb000);
        add_row(1, 1, make_access(op_read, 3, mod_add_j), '0, 1, 16'hb7fd);
        add_idle(2);
        // Interleaved pointers, region q at 0x300 + 16*q
        for (int p = 0; p < 4; p++) begin
            add_row(1, 1, make_instr(op_load_ptr, p, 11'h300 + 16 * p), '0, 0, '0);
        end
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < 4; p++) begin
                add_row(1, 1, make_access(op_write, p, mod_inc), 16'hc000 + 16 * p + k, 0, '0);
            end
        end
        // Each pointer now reads the next pointer's region downwards
        for (int p = 0; p < 4; p++) begin
            add_row(1, 1, make_instr(op_load_ptr, p, 11'h301 + 16 * ((p + 1) % 4)), '0, 0, '0);
        end
        for (int k = 1; k >= 0; k--) begin
            for (int p = 0; p < 4; p++) begin
                add_row(1, 1, make_access(op_read, p, mod_dec), '0, 1,
                        16'hc000 + 16 * ((p + 1) % 4) + k);
            end
        end
        add_idle(2);
        // Stalls between and during instructions
        add_row(1, 1, make_instr(op_load_ptr, 0, 11'h400), '0, 0, '0);
        add_row(0, 0, '0, '0, 0, '0);
        add_row(1, 1, make_access(op_write, 0, mod_inc), 16'hd400, 0, '0);
        add_row(0, 0, '0, '0, 0, '0);
        add_row(1, 1, make_access(op_write, 0, mod_inc), 16'hd401, 0, '0);
        add_row(1, 1, make_instr(op_load_ptr, 1, 11'h400), '0, 0, '0);
        add_row(0, 1, make_access(op_read, 1, mod_inc), '0, 0, '0);
        add_row(1, 1, make_access(op_read, 1, mod_inc), '0, 1, 16'hd400);
        add_row(0, 0, '0, '0, 0, '0);
        add_row(0, 0, '0, '0, 0, '0);
        add_row(1, 0, '0, '0, 0, '0);
        add_row(0, 0, '0, '0, 0, '0);
        add_row(1, 1, make_access(op_read, 1, mod_inc), '0, 1, 16'hd401);
        add_row(1, 0, '0, '0, 0, '0);
        add_row(0, 0, '0, '0, 0, '0);
        add_idle(2);
        // Opcode 6 ignored while stalled, then faults
        add_row(0, 1, make_instr(3'd6, 0, '0), '0, 0, '0);
        add_row(1, 0, '0, '0, 0, '0);
        add_row(1, 1, make_instr(3'd6, 0, '0), '0, 0, '0);
        add_row(1, 1, make_instr(op_load_ptr, 0, 11'd5), '0, 0, '0);
        add_idle(2);
    endtask

    task automatic fill_ram();
        row_t r;
        r       = '0;
        r.cen   = 1'b1;
        r.valid = 1'b1;
        r.instr = make_access(op_write, 0, mod_inc);
        for (int a = 0; a < (1 << default_ram_aw); a++) begin
            r.wdata = fill_word(addr_t'(a));
            drive_row(r);
            ref_ram[a] = r.wdata;
        end
        for (int p = 0; p < num_ptr; p++) begin
            ref_ptr[p] = '0;
        end
        ref_j = '0;
    endtask

    task automatic wait_read(input data_t exp);
        row_t idle;
        logic seen;
        idle = '0;
        seen = 1'b0;
        for (int t = 0; t < 20 && !seen; t++) begin
            lcg_state = lcg_next(lcg_state);
            idle.cen  = lcg_state[27] | lcg_state[26];
            drive_row(idle);
            @(negedge clk);
            seen = rdata_valid;
        end
        if (seen) begin
            check_value("rdata", rdata, exp);
        end else begin
            $display("Timeout: no rdata_valid after a random read");
            fail_run();
        end
    endtask

    task automatic run_random(input int count);
        row_t       r;
        logic [2:0] op;
        logic [1:0] sel;
        addr_t      addr;
        data_t      exp;
        for (int n = 0; n < count; n++) begin
            lcg_state = lcg_next(lcg_state);
            op        = 3'(lcg_state[31:16] % 5);
            sel       = lcg_state[12:11];
            r         = '0;
            r.instr   = {op, sel, lcg_state[10:0]};
            lcg_state = lcg_next(lcg_state);
            r.wdata   = lcg_state[31:16];
            r.valid   = 1'b1;
            // Sometimes present the instruction during a stall first
            if (lcg_state[9]) begin
                drive_row(r);
            end
            r.cen = 1'b1;
            drive_row(r);
            addr = ref_ptr[sel];
            exp  = ref_ram[addr];
            case (op)
                op_load_ptr: ref_ptr[sel] = r.instr[imm_msb:imm_lsb];
                op_load_j:   ref_j = r.instr[imm_msb:imm_lsb];
                op_write:    ref_ram[addr] = r.wdata;
                default:     ;
            endcase
            if (op == op_read || op == op_write) begin
                ref_ptr[sel] = step_ptr(addr, r.instr[mod_msb:mod_lsb], ref_j);
            end
            if (op == op_read) begin
                wait_read(exp);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        cen         = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wdata       = '0;
        lcg_state   = 32'hf25a_b40b;
        apply_reset();
        build_table();
        foreach (rows[n]) begin
            run_row(rows[n]);
        end
        // Second reset clears the fault
        @(posedge clk);
        apply_reset();
        @(negedge clk);
        check_value("fault", fault, 1'b0);
        check_value("rdata_valid", rdata_valid, 1'b0);
        fill_ram();
        run_random(200);
        @(negedge clk);
        check_value("fault", fault, 1'b0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- dsp16_yaau.f
design/dsp16_types_pkg.sv
design/dsp16_isa_pkg.sv
design/yaau_decode.sv
design/yaau_ptr.sv
design/yaau_ram_port.sv
design/dsp16_yaau.sv
testbench/dsp16_yaau_properties.sv
testbench/dsp16_yaau_tb.sv
